/* verilog/hist_defs.svh */
`ifndef HIST_DEFS_SVH
`define HIST_DEFS_SVH

// bin address and count widths
`define HIST_BIN_W 4
`define HIST_CNT_W 16

// frame hierarchy
`define HIST_DATA_NUM 4   // samples per pixel
`define HIST_PIXEL_NUM 3  // pixels per acquisition
`define HIST_ACQ_NUM 2    // acquisitions per frame

// apb address map
`define HIST_APB_AW 8
`define HIST_REG_CTRL 8'h00
`define HIST_REG_STATUS 8'h04
`define HIST_REG_FRAMES 8'h08

// bin window, bin b at base + 4*b
// base must be aligned to the window size
`define HIST_BIN_BASE 8'h40

`endif

/* verilog/hist_types_pkg.sv */
`include "hist_defs.svh"

package hist_types_pkg;

    // sequencer states
    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        INPUT,
        PIXEL,
        ACQ
    } hist_state_e;

    // bin array commands
    typedef enum logic [1:0] {
        OP_NOP,
        OP_CLEAR,
        OP_INCR
    } ram_op_e;

    typedef struct packed {
        logic                   valid;
        logic [`HIST_BIN_W-1:0] bin;
    } hist_sample_t;

    typedef struct packed {
        ram_op_e                op;
        logic [`HIST_BIN_W-1:0] addr;
    } ram_cmd_t;

endpackage

/* verilog/hist_bus_pkg.sv */
`include "hist_defs.svh"

package hist_bus_pkg;

    typedef struct packed {
        logic                    psel;
        logic                    penable;
        logic                    pwrite;
        logic [`HIST_APB_AW-1:0] paddr;
        logic [31:0]             pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // register selects, values are the byte offsets
    typedef enum logic [`HIST_APB_AW-1:0] {
        REG_CTRL   = `HIST_REG_CTRL,
        REG_STATUS = `HIST_REG_STATUS,
        REG_FRAMES = `HIST_REG_FRAMES,
        REG_BIN    = `HIST_BIN_BASE,
        REG_NONE   = {`HIST_APB_AW{1'b1}}
    } hist_reg_e;

endpackage

/* verilog/hist_seq_fsm.sv */
`timescale 1ns/1ps
`include "hist_defs.svh"

module hist_seq_fsm import hist_types_pkg::*; (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   start_pulse,
    input  logic                   clear_last,
    input  logic                   input_last,
    input  logic                   pixel_last,
    input  logic                   acq_last,
    input  hist_sample_t           sample,
    input  logic [`HIST_BIN_W-1:0] clear_addr,
    output logic                   sample_ready,
    output logic                   busy,
    output logic                   frame_done,
    output logic                   bank_sel,
    output logic                   clear_step,
    output logic                   sample_step,
    output logic                   pixel_step,
    output logic                   acq_step,
    output ram_cmd_t               ram_cmd
);
    hist_state_e state;
    hist_state_e state_nxt;
    logic        xfer;
    logic        frame_end;

    assign xfer      = sample.valid && sample_ready;
    assign frame_end = (state == ACQ) && acq_last;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= IDLE;
            bank_sel   <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            state      <= state_nxt;
            frame_done <= frame_end;
            if (frame_end) begin
                bank_sel <= ~bank_sel; // swap accumulate and readout banks
            end
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (start_pulse) state_nxt = CLEAR;
            CLEAR:   if (clear_last) state_nxt = INPUT;
            INPUT:   if (xfer && input_last) state_nxt = PIXEL;
            PIXEL:   state_nxt = pixel_last ? ACQ : INPUT;
            ACQ:     state_nxt = acq_last ? IDLE : INPUT;
            default: state_nxt = IDLE;
        endcase
    end

    assign sample_ready = (state == INPUT);
    assign busy         = (state != IDLE);
    assign clear_step   = (state == CLEAR);
    assign sample_step  = xfer;
    assign pixel_step   = (state == PIXEL);
    assign acq_step     = (state == ACQ);

    always_comb begin
        ram_cmd.op   = OP_NOP;
        ram_cmd.addr = sample.bin;
        if (state == CLEAR) begin
            ram_cmd.op   = OP_CLEAR;
            ram_cmd.addr = clear_addr; // one bin per cycle
        end else if (xfer) begin
            ram_cmd.op = OP_INCR;
        end
    end

endmodule

/* verilog/hist_frame_counter.sv */
`timescale 1ns/1ps
`include "hist_defs.svh"

module hist_frame_counter (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   clear_step,
    input  logic                   sample_step,
    input  logic                   pixel_step,
    input  logic                   acq_step,
    output logic [`HIST_BIN_W-1:0] clear_addr,
    output logic                   clear_last,
    output logic                   input_last,
    output logic                   pixel_last,
    output logic                   acq_last
);
    localparam int SMP_W = $clog2(`HIST_DATA_NUM + 1);
    localparam int PIX_W = $clog2(`HIST_PIXEL_NUM + 1);
    localparam int ACQ_W = $clog2(`HIST_ACQ_NUM + 1);

    localparam logic [SMP_W-1:0] SMP_LAST = SMP_W'(`HIST_DATA_NUM - 1);
    localparam logic [PIX_W-1:0] PIX_LAST = PIX_W'(`HIST_PIXEL_NUM - 1);
    localparam logic [ACQ_W-1:0] ACQ_LAST = ACQ_W'(`HIST_ACQ_NUM - 1);

    logic [SMP_W-1:0] smp_cnt;
    logic [PIX_W-1:0] pix_cnt;
    logic [ACQ_W-1:0] acq_cnt;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clear_addr <= '0;
            smp_cnt    <= '0;
            pix_cnt    <= '0;
            acq_cnt    <= '0;
        end else begin
            if (clear_step) begin
                clear_addr <= clear_addr + 1'b1; // wraps to 0 after last bin
            end
            if (pixel_step) begin
                smp_cnt <= '0;
            end else if (sample_step) begin
                smp_cnt <= smp_cnt + 1'b1;
            end
            if (acq_step) begin
                pix_cnt <= '0;
            end else if (pixel_step) begin
                pix_cnt <= pix_cnt + 1'b1;
            end
            if (acq_step) begin
                acq_cnt <= acq_last ? '0 : acq_cnt + 1'b1;
            end
        end
    end

    // flags mark the step that completes each level
    assign clear_last = (clear_addr == {`HIST_BIN_W{1'b1}});
    assign input_last = (smp_cnt == SMP_LAST);
    assign pixel_last = (pix_cnt == PIX_LAST);
    assign acq_last   = (acq_cnt == ACQ_LAST);

endmodule

/* verilog/hist_bin_ram.sv */
`timescale 1ns/1ps
`include "hist_defs.svh"

module hist_bin_ram import hist_types_pkg::*; (
    input  logic                   clk,
    input  logic                   res,
    input  ram_cmd_t               ram_cmd,
    input  logic                   bank_sel,
    input  logic [`HIST_BIN_W-1:0] rd_addr,
    output logic [`HIST_CNT_W-1:0] rd_count
);
    localparam int NBINS = 1 << `HIST_BIN_W;

    // bank_sel picks the bank being accumulated
    logic [`HIST_CNT_W-1:0] mem [0:1][0:NBINS-1];
    logic [`HIST_CNT_W-1:0] cur;
    logic                   sat;

    assign cur = mem[bank_sel][ram_cmd.addr];
    assign sat = (cur == {`HIST_CNT_W{1'b1}});

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < NBINS; i++) begin
                    mem[b][i] <= '0;
                end
            end
        end else begin
            case (ram_cmd.op)
                OP_CLEAR: begin
                    mem[bank_sel][ram_cmd.addr] <= '0;
                end
                OP_INCR: begin
                    if (!sat) begin
                        mem[bank_sel][ram_cmd.addr] <= cur + 1'b1; // no wrap
                    end
                end
                default: ;
            endcase
        end
    end

    // readout always from the finished bank
    assign rd_count = mem[~bank_sel][rd_addr];

endmodule

/* verilog/hist_apb_regs.sv */
`timescale 1ns/1ps
`include "hist_defs.svh"

module hist_apb_regs import hist_bus_pkg::*; (
    input  logic                   clk,
    input  logic                   res,
    input  apb_req_t               apb_req,
    output apb_rsp_t               apb_rsp,
    input  logic                   busy,
    input  logic                   bank_sel,
    input  logic                   frame_done,
    input  logic [`HIST_CNT_W-1:0] rd_count,
    output logic [`HIST_BIN_W-1:0] rd_addr,
    output logic                   start_pulse,
    output logic                   frame_irq
);
    localparam int AW = `HIST_APB_AW;
    localparam int WIN_LSB = `HIST_BIN_W + 2;
    localparam logic [AW-1:0] BIN_BASE = `HIST_BIN_BASE;

    hist_reg_e   reg_sel;
    logic        access;
    logic        wr_en;
    logic        bin_hit;
    logic        done;
    logic [31:0] frame_cnt;

    assign access  = apb_req.psel && apb_req.penable;
    assign wr_en   = access && apb_req.pwrite;
    assign bin_hit = (apb_req.paddr[AW-1:WIN_LSB] == BIN_BASE[AW-1:WIN_LSB])
                     && (apb_req.paddr[1:0] == 2'b00);
    assign rd_addr = apb_req.paddr[WIN_LSB-1:2];

    always_comb begin
        if (bin_hit) begin
            reg_sel = REG_BIN;
        end else begin
            case (apb_req.paddr)
                REG_CTRL:   reg_sel = REG_CTRL;
                REG_STATUS: reg_sel = REG_STATUS;
                REG_FRAMES: reg_sel = REG_FRAMES;
                default:    reg_sel = REG_NONE;
            endcase
        end
    end

    // ctrl bit 0 is a self-clearing start
    assign start_pulse = wr_en && (reg_sel == REG_CTRL) && apb_req.pwdata[0];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            done      <= 1'b0;
            frame_cnt <= '0;
        end else begin
            if (frame_done) begin
                done      <= 1'b1; // set wins over a same-cycle clear
                frame_cnt <= frame_cnt + 1'b1;
            end else if (wr_en && (reg_sel == REG_STATUS) && apb_req.pwdata[1]) begin
                done <= 1'b0;
            end
        end
    end

    assign frame_irq = done;

    always_comb begin
        case (reg_sel)
            REG_STATUS: apb_rsp.prdata = {29'b0, bank_sel, done, busy};
            REG_FRAMES: apb_rsp.prdata = frame_cnt;
            REG_BIN:    apb_rsp.prdata = {{(32-`HIST_CNT_W){1'b0}}, rd_count};
            default:    apb_rsp.prdata = '0;
        endcase
    end

    assign apb_rsp.pready  = 1'b1; // no wait states
    assign apb_rsp.pslverr = access && (reg_sel == REG_NONE);

endmodule

/* verilog/hist_builder_top.sv */
`timescale 1ns/1ps
`include "hist_defs.svh"

module hist_builder_top import hist_types_pkg::*, hist_bus_pkg::*; (
    input  logic         clk,
    input  logic         res,
    input  hist_sample_t sample,
    output logic         sample_ready,
    input  apb_req_t     apb_req,
    output apb_rsp_t     apb_rsp,
    output logic         frame_irq
);
    logic                   start_pulse;
    logic                   busy;
    logic                   frame_done;
    logic                   bank_sel;
    logic                   clear_step;
    logic                   sample_step;
    logic                   pixel_step;
    logic                   acq_step;
    logic [`HIST_BIN_W-1:0] clear_addr;
    logic                   clear_last;
    logic                   input_last;
    logic                   pixel_last;
    logic                   acq_last;
    ram_cmd_t               ram_cmd;
    logic [`HIST_BIN_W-1:0] rd_addr;
    logic [`HIST_CNT_W-1:0] rd_count;

    hist_seq_fsm seq_i (
        .clk          (clk),
        .res          (res),
        .start_pulse  (start_pulse),
        .clear_last   (clear_last),
        .input_last   (input_last),
        .pixel_last   (pixel_last),
        .acq_last     (acq_last),
        .sample       (sample),
        .clear_addr   (clear_addr),
        .sample_ready (sample_ready),
        .busy         (busy),
        .frame_done   (frame_done),
        .bank_sel     (bank_sel),
        .clear_step   (clear_step),
        .sample_step  (sample_step),
        .pixel_step   (pixel_step),
        .acq_step     (acq_step),
        .ram_cmd      (ram_cmd)
    );

    hist_frame_counter cnt_i (
        .clk         (clk),
        .res         (res),
        .clear_step  (clear_step),
        .sample_step (sample_step),
        .pixel_step  (pixel_step),
        .acq_step    (acq_step),
        .clear_addr  (clear_addr),
        .clear_last  (clear_last),
        .input_last  (input_last),
        .pixel_last  (pixel_last),
        .acq_last    (acq_last)
    );

    hist_bin_ram ram_i (
        .clk      (clk),
        .res      (res),
        .ram_cmd  (ram_cmd),
        .bank_sel (bank_sel),
        .rd_addr  (rd_addr),
        .rd_count (rd_count)
    );

    hist_apb_regs regs_i (
        .clk         (clk),
        .res         (res),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .busy        (busy),
        .bank_sel    (bank_sel),
        .frame_done  (frame_done),
        .rd_count    (rd_count),
        .rd_addr     (rd_addr),
        .start_pulse (start_pulse),
        .frame_irq   (frame_irq)
    );

endmodule

/* tb/hist_builder_sva.sv */
`timescale 1ns/1ps

module hist_builder_sva import hist_types_pkg::*; (
    input logic        clk,
    input logic        res,
    input hist_state_e state,
    input logic        sample_ready,
    input logic        frame_done,
    input logic        bank_sel,
    input logic        pready
);

    // stream accepted only while counting samples
    ready_only_in_input: assert property (
        @(posedge clk) disable iff (!res)
        sample_ready |-> (state == INPUT)
    ) else $error("sample_ready high outside the INPUT state");

    frame_done_one_cycle: assert property (
        @(posedge clk) disable iff (!res)
        frame_done |=> !frame_done
    ) else $error("frame_done held for more than one cycle");

    // bank_sel and frame_done come from the same edge
    bank_swap_with_done: assert property (
        @(posedge clk) disable iff (!res)
        $changed(bank_sel) |-> frame_done
    ) else $error("bank_sel changed without frame_done");

    no_wait_states: assert property (
        @(posedge clk) disable iff (!res)
        pready
    ) else $error("pready went low");

endmodule

bind hist_builder_top hist_builder_sva sva_i (
    .clk          (clk),
    .res          (res),
    .state        (seq_i.state),
    .sample_ready (sample_ready),
    .frame_done   (frame_done),
    .bank_sel     (bank_sel),
    .pready       (apb_rsp.pready)
);

/* tb/hist_builder_tb.sv */
`timescale 1ns/1ps
`include "hist_defs.svh"

module hist_builder_tb import hist_types_pkg::*, hist_bus_pkg::*; ();

    localparam int NBINS = 1 << `HIST_BIN_W;
    localparam int FRAME_SAMPLES = `HIST_DATA_NUM * `HIST_PIXEL_NUM * `HIST_ACQ_NUM;
    // clear, input, pixel and acq phases plus some bus overhead
    localparam int FRAME_CYCLES = NBINS + FRAME_SAMPLES
                                  + `HIST_PIXEL_NUM * `HIST_ACQ_NUM + `HIST_ACQ_NUM + 8;
    localparam int PERIOD = 100;
    localparam int WAIT_LIMIT = 4 * FRAME_CYCLES;

    typedef enum logic [2:0] {
        STEP_WR,    // apb write
        STEP_RD,    // apb read with masked compare
        STEP_BURST, // wdata samples into the stream
        STEP_WAIT,  // until frame_irq
        STEP_BINS,  // all bins against the model and exp as their sum
        STEP_PINS   // exp[0] frame_irq, exp[1] sample_ready
    } step_op_e;

    typedef struct packed {
        step_op_e                op;
        logic [`HIST_APB_AW-1:0] addr;
        logic [31:0]             wdata;
        logic [31:0]             exp;
        logic [31:0]             mask;
        logic                    err;
    } step_t;

    logic         clk;
    logic         res;
    hist_sample_t sample;
    logic         sample_ready;
    apb_req_t     apb_req;
    apb_rsp_t     apb_rsp;
    logic         frame_irq;

    step_t        steps[$];
    logic         table_ready = 1'b0;
    logic [7:0]   lfsr = 8'd18;
    int unsigned  model [NBINS] = '{default: 0};

    hist_builder_top dut_i (
        .clk          (clk),
        .res          (res),
        .sample       (sample),
        .sample_ready (sample_ready),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .frame_irq    (frame_irq)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        // galois form of x^8 + x^6 + x^5 + x^4 + 1
        return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
    endfunction

    function automatic logic [`HIST_BIN_W-1:0] random_bin();
        logic [`HIST_BIN_W-1:0] bin;
        for (int i = 0; i < `HIST_BIN_W; i++) begin
            bin[i] = lfsr[0]; // one step per bit
            lfsr = lfsr_next(lfsr);
        end
        return bin;
    endfunction

    function automatic void add_step(input step_op_e op, input logic [7:0] addr,
                                     input logic [31:0] wdata, input logic [31:0] exp,
                                     input logic [31:0] mask, input logic err);
        steps.push_back(step_t'{op, addr, wdata, exp, mask, err});
    endfunction

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= 1'b1;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= data;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= 1'b0;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= '0;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk); // access phase has no wait states
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic run_burst(input int n);
        int                     count;
        int                     cycles;
        logic [`HIST_BIN_W-1:0] bin;
        count  = 0;
        cycles = 0;
        @(posedge clk);
        bin = random_bin();
        sample <= {1'b1, bin};
        while (count < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("sample burst stalled, only %0d of %0d samples taken", count, n);
                abort_run();
            end
            if (sample.valid && sample_ready) begin
                model[sample.bin] += 1; // counted only on a real transfer
                count++;
                @(posedge clk);
                if (count < n) begin
                    bin = random_bin();
                    sample <= {1'b1, bin};
                end else begin
                    sample <= '0;
                end
            end
        end
    endtask

    task automatic wait_frame();
        int cycles;
        cycles = 0;
        while (frame_irq !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("frame never completed, frame_irq stayed low");
                abort_run();
            end
        end
    endtask

    task automatic read_bins(input logic [31:0] exp_sum);
        logic [31:0] data;
        logic        err;
        logic [31:0] sum;
        string       name;
        sum = '0;
        for (int b = 0; b < NBINS; b++) begin
            apb_read(`HIST_BIN_BASE + 8'(4 * b), data, err);
            name = $sformatf("bin[%0d]", b);
            check_value(name, data, model[b]);
            check_value({name, " pslverr"}, {31'b0, err}, 32'h0);
            sum = sum + data;
        end
        check_value("bin sum", sum, exp_sum);
        for (int b = 0; b < NBINS; b++) begin
            model[b] = 0; // next frame starts from an empty model
        end
    endtask

    task automatic load_steps();
        // after reset
        add_step(STEP_PINS, 8'h00, 32'h0, 32'h0, 32'h3, 1'b0);
        add_step(STEP_RD, `HIST_REG_STATUS, 32'h0, 32'h0, 32'hFFFF_FFFF, 1'b0);
        add_step(STEP_RD, `HIST_REG_FRAMES, 32'h0, 32'h0, 32'hFFFF_FFFF, 1'b0);
        add_step(STEP_RD, 8'h0C, 32'h0, 32'h0, 32'hFFFF_FFFF, 1'b1);
        // first frame with valid already high during CLEAR
        add_step(STEP_WR, `HIST_REG_CTRL, 32'h1, 32'h0, 32'h0, 1'b0);
        add_step(STEP_RD, `HIST_REG_STATUS, 32'h0, 32'h1, 32'h1, 1'b0);
        add_step(STEP_BURST, 8'h00, FRAME_SAMPLES, 32'h0, 32'h0, 1'b0);
        add_step(STEP_WAIT, 8'h00, 32'h0, 32'h0, 32'h0, 1'b0);
        add_step(STEP_RD, `HIST_REG_STATUS, 32'h0, 32'h6, 32'h7, 1'b0);
        add_step(STEP_PINS, 8'h00, 32'h0, 32'h1, 32'h3, 1'b0);
        add_step(STEP_BINS, 8'h00, 32'h0, FRAME_SAMPLES, 32'h0, 1'b0);
        add_step(STEP_RD, `HIST_REG_FRAMES, 32'h0, 32'h1, 32'hFFFF_FFFF, 1'b0);
        add_step(STEP_WR, `HIST_REG_STATUS, 32'h2, 32'h0, 32'h0, 1'b0);
        add_step(STEP_RD, `HIST_REG_STATUS, 32'h0, 32'h4, 32'hFFFF_FFFF, 1'b0);
        add_step(STEP_PINS, 8'h00, 32'h0, 32'h0, 32'h3, 1'b0);
        // second frame brings the bank bit back to 0
        add_step(STEP_WR, `HIST_REG_CTRL, 32'h1, 32'h0, 32'h0, 1'b0);
        add_step(STEP_BURST, 8'h00, FRAME_SAMPLES, 32'h0, 32'h0, 1'b0);
        add_step(STEP_WAIT, 8'h00, 32'h0, 32'h0, 32'h0, 1'b0);
        add_step(STEP_RD, `HIST_REG_STATUS, 32'h0, 32'h2, 32'h7, 1'b0);
        add_step(STEP_BINS, 8'h00, 32'h0, FRAME_SAMPLES, 32'h0, 1'b0);
        add_step(STEP_WR, `HIST_REG_STATUS, 32'h2, 32'h0, 32'h0, 1'b0);
        add_step(STEP_PINS, 8'h00, 32'h0, 32'h0, 32'h3, 1'b0);
        add_step(STEP_RD, `HIST_REG_FRAMES, 32'h0, 32'h2, 32'hFFFF_FFFF, 1'b0);
        // third frame reuses bank 0 while a second start lands in INPUT
        add_step(STEP_WR, `HIST_REG_CTRL, 32'h1, 32'h0, 32'h0, 1'b0);
        add_step(STEP_BURST, 8'h00, FRAME_SAMPLES / 2, 32'h0, 32'h0, 1'b0);
        add_step(STEP_WR, `HIST_REG_CTRL, 32'h1, 32'h0, 32'h0, 1'b0);
        add_step(STEP_BURST, 8'h00, FRAME_SAMPLES / 2, 32'h0, 32'h0, 1'b0);
        add_step(STEP_WAIT, 8'h00, 32'h0, 32'h0, 32'h0, 1'b0);
        add_step(STEP_RD, `HIST_REG_FRAMES, 32'h0, 32'h3, 32'hFFFF_FFFF, 1'b0);
        add_step(STEP_RD, `HIST_REG_STATUS, 32'h0, 32'h6, 32'h7, 1'b0);
        add_step(STEP_BINS, 8'h00, 32'h0, FRAME_SAMPLES, 32'h0, 1'b0);
        add_step(STEP_RD, 8'h02, 32'h0, 32'h0, 32'hFFFF_FFFF, 1'b1);
        add_step(STEP_RD, 8'hFC, 32'h0, 32'h0, 32'hFFFF_FFFF, 1'b1);
    endtask

    // watchdog sized from the table
    initial begin
        wait (table_ready);
        #(longint'(steps.size()) * FRAME_CYCLES * PERIOD);
        $display("timeout, the run did not finish");
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        step_t       s;
        logic [31:0] data;
        logic        err;
        res     <= 1'b0;
        sample  <= '0;
        apb_req <= '0;
        load_steps();
        table_ready = 1'b1;
        repeat (4) @(posedge clk);
        res <= 1'b1;
        foreach (steps[i]) begin
            s = steps[i];
            case (s.op)
                STEP_WR:    apb_write(s.addr, s.wdata);
                STEP_RD: begin
                    apb_read(s.addr, data, err);
                    check_value($sformatf("prdata at 0x%02h", s.addr),
                                data & s.mask, s.exp & s.mask);
                    check_value($sformatf("pslverr at 0x%02h", s.addr),
                                {31'b0, err}, {31'b0, s.err});
                end
                STEP_BURST: run_burst(int'(s.wdata));
                STEP_WAIT:  wait_frame();
                STEP_BINS:  read_bins(s.exp);
                STEP_PINS: begin
                    @(negedge clk);
                    check_value("frame_irq", {31'b0, frame_irq}, {31'b0, s.exp[0]});
                    check_value("sample_ready", {31'b0, sample_ready}, {31'b0, s.exp[1]});
                end
                default: begin
                    $display("unknown step kind in row %0d", i);
                    abort_run();
                end
            endcase
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

/* hist_builder_top.f */
+incdir+verilog
verilog/hist_types_pkg.sv
verilog/hist_bus_pkg.sv
verilog/hist_seq_fsm.sv
verilog/hist_frame_counter.sv
verilog/hist_bin_ram.sv
verilog/hist_apb_regs.sv
verilog/hist_builder_top.sv
tb/hist_builder_sva.sv
tb/hist_builder_tb.sv

/* Makefile */
# Verilator build and run for the histogram builder testbench

TOP = hist_builder_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): hist_builder_top.f $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f hist_builder_top.f

# the log decides pass or fail
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
